//--- common/hbus_axi_pkg.sv
package hbus_axi_pkg;

    // ======================================
    // Widths
    // ======================================

    localparam int unsigned AXI_ADDR_W     = 32;
    localparam int unsigned AXI_DATA_W     = 64;
    localparam int unsigned AXI_ID_W       = 4;
    localparam int unsigned AXI_STRB_W     = AXI_DATA_W / 8;

    // 16-bit words in one full data beat
    localparam int unsigned WORDS_PER_BEAT = AXI_DATA_W / 16;
    localparam int unsigned WORD_IDX_W     = $clog2(WORDS_PER_BEAT);

    // ======================================
    // Vector types
    // ======================================

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [7:0]            axi_len_t;
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_resp_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    // ======================================
    // Channel payloads
    // ======================================

    // Shared by AW and AR
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
        axi_size_t size;
        logic [1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

endpackage

//--- common/hbus_phy_pkg.sv
package hbus_phy_pkg;

    // ======================================
    // Widths
    // ======================================

    localparam int unsigned NUM_CHIPS   = 2;
    localparam int unsigned BLEN_W      = 16;
    localparam int unsigned WORD_ADDR_W = 31;

    // ======================================
    // Vector types
    // ======================================

    typedef logic [15:0]            hyper_word_t;
    typedef logic [BLEN_W-1:0]      hyper_blen_t;
    typedef logic [WORD_ADDR_W-1:0] hyper_waddr_t;

    // One bit per chip, one-hot
    typedef logic [NUM_CHIPS-1:0]   chip_cs_t;

    // ======================================
    // PHY channel payloads
    // ======================================

    typedef struct packed {
        hyper_word_t data;
        logic [1:0]  strb;
        logic        last;
    } hyper_tx_t;

    typedef struct packed {
        hyper_word_t data;
        logic        last;
        logic        error;
    } hyper_rx_t;

    // Transfer descriptor, burst counts 16-bit words
    typedef struct packed {
        logic         write;
        logic         burst_type;
        logic         address_space;
        hyper_waddr_t address;
        hyper_blen_t  burst;
    } hyper_tf_t;

endpackage

//--- hbus_axi/hbus_ax_channel.sv
`timescale 1ns/1ns

module hbus_ax_channel import hbus_axi_pkg::*, hbus_phy_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  axi_ax_t    aw_i,
    input  logic       aw_valid_i,
    input  axi_ax_t    ar_i,
    input  logic       ar_valid_i,
    input  logic       busy_i,
    input  logic       trans_ready_i,
    input  logic [4:0] addr_mask_msb_i,
    input  logic       addr_space_i,
    output logic       aw_ready_o,
    output logic       ar_ready_o,
    output hyper_tf_t  trans_o,
    output chip_cs_t   trans_cs_o,
    output logic       trans_valid_o,
    output logic       ax_fire_o,
    output axi_ax_t    ax_o,
    output logic       ax_write_o
);

    // Priority bit, high when AW wins a tie
    logic prio_aw_q;
    logic lock_q;
    logic lock_write_q;

    logic        sel_write;
    axi_addr_t   masked_addr;
    hyper_blen_t blen_beats;

    // ======================================
    // Arbitration
    // ======================================

    always_comb begin
        if (lock_q) begin
            sel_write = lock_write_q;
        end else if (aw_valid_i && ar_valid_i) begin
            sel_write = prio_aw_q;
        end else begin
            sel_write = aw_valid_i;
        end
    end

    assign ax_o          = sel_write ? aw_i : ar_i;
    assign ax_write_o    = sel_write;
    assign trans_valid_o = ~busy_i & (sel_write ? aw_valid_i : ar_valid_i);
    assign ax_fire_o     = trans_valid_o & trans_ready_i;
    assign aw_ready_o    = ax_fire_o & sel_write;
    assign ar_ready_o    = ax_fire_o & ~sel_write;

    // Hold the offered channel until the PHY takes it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_aw_q    <= 1'b0;
            lock_q       <= 1'b0;
            lock_write_q <= 1'b0;
        end else begin
            lock_q       <= trans_valid_o & ~trans_ready_i;
            lock_write_q <= sel_write;
            if (ax_fire_o) begin
                prio_aw_q <= ~sel_write;
            end
        end
    end

    // ======================================
    // Translation
    // ======================================

    assign masked_addr = ax_o.addr & ~(axi_addr_t'('1) << addr_mask_msb_i);
    assign blen_beats  = hyper_blen_t'(ax_o.len) + hyper_blen_t'(1);

    always_comb begin
        trans_o.write         = sel_write;
        trans_o.burst_type    = 1'b1;
        trans_o.address_space = addr_space_i;
        trans_o.address       = masked_addr[AXI_ADDR_W-1:1];
        // Words per beat are 2^(size-1)
        trans_o.burst         = blen_beats << (ax_o.size - 3'd1);
    end

    // Chip index is the first address bit above the mask
    always_comb begin
        trans_cs_o = '0;
        trans_cs_o[ax_o.addr[addr_mask_msb_i]] = 1'b1;
    end

endmodule

//--- hbus_axi/hbus_xfer_tracker.sv
`timescale 1ns/1ns

module hbus_xfer_tracker import hbus_axi_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      ax_fire_i,
    input  axi_ax_t   ax_i,
    input  logic      ax_write_i,
    input  logic      rx_fire_i,
    input  logic      rx_last_fire_i,
    input  logic      tx_fire_i,
    input  logic      tx_last_fire_i,
    input  logic      b_error_i,
    input  logic      b_valid_i,
    input  logic      b_ready_i,
    output word_idx_t word_idx_o,
    output logic      endbeat_o,
    output axi_id_t   id_o,
    output logic      w_enable_o,
    output logic      trans_active_o,
    output axi_b_t    b_o,
    output logic      b_valid_o,
    output logic      b_ready_o
);

    axi_size_t size_q;
    word_idx_t word_idx_q;
    axi_id_t   id_q;
    logic      active_q;
    logic      w_enable_q;

    logic      active_clr;

    // ======================================
    // Word index and beat end
    // ======================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            size_q     <= '0;
            word_idx_q <= '0;
        end else if (ax_fire_i) begin
            size_q     <= ax_i.size;
            word_idx_q <= ax_i.addr[2:1];
        end else if (rx_fire_i || tx_fire_i) begin
            word_idx_q <= word_idx_q + word_idx_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ax_fire_i) begin
            id_q <= ax_i.id;
        end
    end

    // Beat ends when the low size-1 index bits are all set
    always_comb begin
        case (size_q)
            3'd2:    endbeat_o = word_idx_q[0];
            3'd3:    endbeat_o = &word_idx_q;
            default: endbeat_o = 1'b1;
        endcase
    end

    assign word_idx_o = word_idx_q;
    assign id_o       = id_q;

    // ======================================
    // Transfer flags
    // ======================================

    assign active_clr = rx_last_fire_i | (b_valid_i & b_ready_i);

    // A set wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q   <= 1'b0;
            w_enable_q <= 1'b0;
        end else begin
            if (ax_fire_i) begin
                active_q <= 1'b1;
            end else if (active_clr) begin
                active_q <= 1'b0;
            end
            if (ax_fire_i && ax_write_i) begin
                w_enable_q <= 1'b1;
            end else if (tx_last_fire_i) begin
                w_enable_q <= 1'b0;
            end
        end
    end

    assign trans_active_o = active_q;
    assign w_enable_o     = w_enable_q;

    // B response passes straight through
    assign b_o.id    = id_q;
    assign b_o.resp  = b_error_i ? RESP_SLVERR : RESP_OKAY;
    assign b_valid_o = b_valid_i;
    assign b_ready_o = b_ready_i;

endmodule

//--- hbus_axi/hbus_r_coalesce.sv
`timescale 1ns/1ns

module hbus_r_coalesce import hbus_axi_pkg::*, hbus_phy_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  hyper_rx_t rx_i,
    input  logic      rx_valid_i,
    input  word_idx_t word_idx_i,
    input  logic      endbeat_i,
    input  axi_id_t   id_i,
    input  logic      r_ready_i,
    output logic      rx_ready_o,
    output logic      rx_fire_o,
    output logic      rx_last_fire_o,
    output axi_r_t    r_o,
    output logic      r_valid_o
);

    axi_data_t data_q;
    logic      error_q;
    logic      last_q;
    logic      valid_q;

    logic      pop;

    // A full beat stalls RX until R takes it
    assign pop            = valid_q & r_ready_i;
    assign rx_ready_o     = ~valid_q | r_ready_i;
    assign rx_fire_o      = rx_valid_i & rx_ready_o;
    assign rx_last_fire_o = rx_fire_o & rx_i.last;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            error_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            if (pop) begin
                valid_q <= 1'b0;
                error_q <= 1'b0;
            end
            // Push after pop so a word can land in the freed buffer
            if (rx_fire_o) begin
                valid_q <= endbeat_i | rx_i.last;
                error_q <= (error_q & ~pop) | rx_i.error;
                last_q  <= rx_i.last;
            end
        end
    end

    // Lane write of the incoming word
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < WORDS_PER_BEAT; i++) begin
            if (rx_fire_o && word_idx_i == word_idx_t'(i)) begin
                data_q[$bits(hyper_word_t)*i +: $bits(hyper_word_t)] <= rx_i.data;
            end
        end
    end

    assign r_o.id    = id_i;
    assign r_o.data  = data_q;
    assign r_o.resp  = error_q ? RESP_SLVERR : RESP_OKAY;
    assign r_o.last  = last_q;
    assign r_valid_o = valid_q;

endmodule

//--- hbus_axi/hbus_w_serialize.sv
`timescale 1ns/1ns

module hbus_w_serialize import hbus_axi_pkg::*, hbus_phy_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  axi_w_t    w_i,
    input  logic      w_valid_i,
    input  logic      w_enable_i,
    input  word_idx_t word_idx_i,
    input  logic      endbeat_i,
    input  logic      tx_ready_i,
    output logic      w_ready_o,
    output hyper_tx_t tx_o,
    output logic      tx_valid_o,
    output logic      tx_fire_o,
    output logic      tx_last_fire_o
);

    // ======================================
    // W skid buffer
    // ======================================

    axi_w_t     buf_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;

    axi_w_t     head;
    logic       push;
    logic       pop;

    // Ready depends only on the occupancy register
    assign w_ready_o = (count_q != 2'd2);
    assign push      = w_valid_i & w_ready_o;
    assign pop       = tx_fire_o & endbeat_i;
    assign head      = buf_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= w_i;
        end
    end

    // ======================================
    // Word split
    // ======================================

    // Only released once the AW of this write has been accepted
    assign tx_valid_o = w_enable_i & (count_q != 2'd0);

    assign tx_o.data = head.data[$bits(hyper_word_t)*word_idx_i +: $bits(hyper_word_t)];
    assign tx_o.strb = head.strb[2*word_idx_i +: 2];
    assign tx_o.last = head.last & endbeat_i;

    assign tx_fire_o      = tx_valid_o & tx_ready_i;
    assign tx_last_fire_o = tx_fire_o & tx_o.last;

endmodule

//--- hbus_axi/hbus_axi_top.sv
`timescale 1ns/1ns

module hbus_axi_top import hbus_axi_pkg::*, hbus_phy_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // AXI subordinate port
    input  axi_ax_t   aw_i,
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  axi_ax_t   ar_i,
    input  logic      ar_valid_i,
    output logic      ar_ready_o,
    input  axi_w_t    w_i,
    input  logic      w_valid_i,
    output logic      w_ready_o,
    output axi_r_t    r_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,
    output axi_b_t    b_o,
    output logic      b_valid_o,
    input  logic      b_ready_i,
    // PHY port
    input  hyper_rx_t rx_i,
    input  logic      rx_valid_i,
    output logic      rx_ready_o,
    output hyper_tx_t tx_o,
    output logic      tx_valid_o,
    input  logic      tx_ready_i,
    input  logic      b_error_i,
    input  logic      b_valid_i,
    output logic      b_ready_o,
    output hyper_tf_t trans_o,
    output chip_cs_t  trans_cs_o,
    output logic      trans_valid_o,
    input  logic      trans_ready_i,
    // Configuration and status
    input  logic [4:0] addr_mask_msb_i,
    input  logic      addr_space_i,
    output logic      trans_active_o
);

    logic      ax_fire;
    axi_ax_t   ax;
    logic      ax_write;
    word_idx_t word_idx;
    logic      endbeat;
    axi_id_t   id;
    logic      w_enable;
    logic      rx_fire;
    logic      rx_last_fire;
    logic      tx_fire;
    logic      tx_last_fire;

    // ======================================
    // Address channels
    // ======================================

    // New descriptors are held off while a transfer is active
    hbus_ax_channel i_ax_channel (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .aw_i            ( aw_i            ),
        .aw_valid_i      ( aw_valid_i      ),
        .ar_i            ( ar_i            ),
        .ar_valid_i      ( ar_valid_i      ),
        .busy_i          ( trans_active_o  ),
        .trans_ready_i   ( trans_ready_i   ),
        .addr_mask_msb_i ( addr_mask_msb_i ),
        .addr_space_i    ( addr_space_i    ),
        .aw_ready_o      ( aw_ready_o      ),
        .ar_ready_o      ( ar_ready_o      ),
        .trans_o         ( trans_o         ),
        .trans_cs_o      ( trans_cs_o      ),
        .trans_valid_o   ( trans_valid_o   ),
        .ax_fire_o       ( ax_fire         ),
        .ax_o            ( ax              ),
        .ax_write_o      ( ax_write        )
    );

    // ======================================
    // Transfer state and B response
    // ======================================

    hbus_xfer_tracker i_xfer_tracker (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .ax_fire_i      ( ax_fire        ),
        .ax_i           ( ax             ),
        .ax_write_i     ( ax_write       ),
        .rx_fire_i      ( rx_fire        ),
        .rx_last_fire_i ( rx_last_fire   ),
        .tx_fire_i      ( tx_fire        ),
        .tx_last_fire_i ( tx_last_fire   ),
        .b_error_i      ( b_error_i      ),
        .b_valid_i      ( b_valid_i      ),
        .b_ready_i      ( b_ready_i      ),
        .word_idx_o     ( word_idx       ),
        .endbeat_o      ( endbeat        ),
        .id_o           ( id             ),
        .w_enable_o     ( w_enable       ),
        .trans_active_o ( trans_active_o ),
        .b_o            ( b_o            ),
        .b_valid_o      ( b_valid_o      ),
        .b_ready_o      ( b_ready_o      )
    );

    // ======================================
    // Data paths
    // ======================================

    hbus_r_coalesce i_r_coalesce (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .rx_i           ( rx_i         ),
        .rx_valid_i     ( rx_valid_i   ),
        .word_idx_i     ( word_idx     ),
        .endbeat_i      ( endbeat      ),
        .id_i           ( id           ),
        .r_ready_i      ( r_ready_i    ),
        .rx_ready_o     ( rx_ready_o   ),
        .rx_fire_o      ( rx_fire      ),
        .rx_last_fire_o ( rx_last_fire ),
        .r_o            ( r_o          ),
        .r_valid_o      ( r_valid_o    )
    );

    hbus_w_serialize i_w_serialize (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .w_i            ( w_i          ),
        .w_valid_i      ( w_valid_i    ),
        .w_enable_i     ( w_enable     ),
        .word_idx_i     ( word_idx     ),
        .endbeat_i      ( endbeat      ),
        .tx_ready_i     ( tx_ready_i   ),
        .w_ready_o      ( w_ready_o    ),
        .tx_o           ( tx_o         ),
        .tx_valid_o     ( tx_valid_o   ),
        .tx_fire_o      ( tx_fire      ),
        .tx_last_fire_o ( tx_last_fire )
    );

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held for the first 10 cycles
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- sim/tb_hbus_axi_top.sv
`timescale 1ns/1ns

module tb_hbus_axi_top import hbus_axi_pkg::*, hbus_phy_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       rst_n;
    axi_ax_t    aw;
    axi_ax_t    ar;
    axi_w_t     w;
    axi_r_t     r;
    axi_b_t     b;
    hyper_rx_t  rx;
    hyper_tx_t  tx;
    hyper_tf_t  trans;
    chip_cs_t   trans_cs;
    logic       aw_valid;
    logic       aw_ready;
    logic       ar_valid;
    logic       ar_ready;
    logic       w_valid;
    logic       w_ready;
    logic       r_valid;
    logic       r_ready;
    logic       b_valid;
    logic       b_ready;
    logic       rx_valid;
    logic       rx_ready;
    logic       tx_valid;
    logic       tx_ready;
    logic       phy_b_error;
    logic       phy_b_valid;
    logic       phy_b_ready;
    logic       trans_valid;
    logic       trans_ready;
    logic       trans_active;
    logic [4:0] addr_mask_msb;
    logic       addr_space;

    // Expected data of the current write and read
    axi_data_t   w_data [16];
    axi_strb_t   w_strb [16];
    hyper_word_t rx_data [64];
    logic        rx_err [64];

    logic [31:0] lfsr_q = 32'hf637;
    logic        stall_en;
    logic        next_tie_write;
    int unsigned cycle_cnt;

    tb_clk_gen i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    hbus_axi_top dut_i (
        .clk_i (clk), .rst_ni (rst_n),
        .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
        .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
        .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready),
        .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready),
        .rx_i (rx), .rx_valid_i (rx_valid), .rx_ready_o (rx_ready),
        .tx_o (tx), .tx_valid_o (tx_valid), .tx_ready_i (tx_ready),
        .b_error_i (phy_b_error), .b_valid_i (phy_b_valid), .b_ready_o (phy_b_ready),
        .trans_o (trans), .trans_cs_o (trans_cs), .trans_valid_o (trans_valid),
        .trans_ready_i (trans_ready), .addr_mask_msb_i (addr_mask_msb),
        .addr_space_i (addr_space), .trans_active_o (trans_active)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // No new descriptor while a transfer is still open
    always @(negedge clk) begin
        if (rst_n === 1'b1 && trans_valid) begin
            check_value("trans_active_o", trans_active, 0);
        end
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    function automatic logic ready_bit();
        if (!stall_en) begin
            return 1'b1;
        end
        return lfsr_next_bit();
    endfunction

    function automatic int words_per_beat(input axi_size_t size);
        return 1 << (int'(size) - 1);
    endfunction

    function automatic axi_ax_t make_ax(input axi_size_t size, input axi_len_t len);
        axi_ax_t ax;
        ax.id    = axi_id_t'(random_bits(AXI_ID_W));
        ax.addr  = axi_addr_t'(random_bits(AXI_ADDR_W)) & ~((axi_addr_t'(1) << size) - 1);
        ax.len   = len;
        ax.size  = size;
        ax.burst = 2'b01;
        return ax;
    endfunction

    function automatic void fill_w(input axi_ax_t ax);
        for (int i = 0; i <= ax.len; i++) begin
            w_data[i] = random_bits(64);
            w_strb[i] = axi_strb_t'(random_bits(AXI_STRB_W));
        end
    endfunction

    // err_word picks the RX word that carries an error or is -1 for none
    function automatic void fill_rx(input axi_ax_t ax, input int err_word);
        for (int n = 0; n < (ax.len + 1) * words_per_beat(ax.size); n++) begin
            rx_data[n] = hyper_word_t'(random_bits(16));
            rx_err[n]  = (n == err_word);
        end
    endfunction

    // ========================================
    // AXI manager side
    // ========================================

    task automatic send_ax(input logic write, input axi_ax_t ax);
        @(posedge clk);
        if (write) begin
            aw       <= ax;
            aw_valid <= 1'b1;
        end else begin
            ar       <= ax;
            ar_valid <= 1'b1;
        end
        @(negedge clk);
        while (!(write ? aw_ready : ar_ready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (write) begin
            aw_valid <= 1'b0;
        end else begin
            ar_valid <= 1'b0;
        end
    endtask

    task automatic send_w(input axi_ax_t ax);
        for (int i = 0; i <= ax.len; i++) begin
            @(posedge clk);
            w.data  <= w_data[i];
            w.strb  <= w_strb[i];
            w.last  <= (i == ax.len);
            w_valid <= 1'b1;
            @(negedge clk);
            while (!w_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        w_valid <= 1'b0;
    endtask

    task automatic recv_b(input axi_id_t id, input logic err);
        do begin
            @(posedge clk);
            b_ready <= ready_bit();
            @(negedge clk);
        end while (!(b_valid && b_ready));
        check_value("b_o.id", b.id, id);
        check_value("b_o.resp", b.resp, err ? RESP_SLVERR : RESP_OKAY);
        @(posedge clk);
        b_ready <= 1'b0;
    endtask

    // Beat n holds RX words in the lanes that follow the start address
    task automatic recv_r(input axi_ax_t ax);
        int        wpb;
        int        n;
        int        lane;
        axi_data_t exp_data;
        axi_data_t mask;
        logic      err;
        wpb = words_per_beat(ax.size);
        for (int beat = 0; beat <= ax.len; beat++) begin
            do begin
                @(posedge clk);
                r_ready <= ready_bit();
                @(negedge clk);
            end while (!(r_valid && r_ready));
            exp_data = '0;
            mask     = '0;
            err      = 1'b0;
            for (int j = 0; j < wpb; j++) begin
                n    = beat * wpb + j;
                lane = (int'(ax.addr[2:1]) + n) % WORDS_PER_BEAT;
                exp_data[16*lane +: 16] = rx_data[n];
                mask[16*lane +: 16]     = 16'hffff;
                err |= rx_err[n];
            end
            check_value("r_o.id", r.id, ax.id);
            check_value("r_o.data", r.data & mask, exp_data);
            check_value("r_o.resp", r.resp, err ? RESP_SLVERR : RESP_OKAY);
            check_value("r_o.last", r.last, beat == ax.len);
        end
        @(posedge clk);
        r_ready <= 1'b0;
    endtask

    // ========================================
    // PHY side
    // ========================================

    task automatic accept_trans(input axi_ax_t ax, input logic write);
        axi_addr_t exp_addr;
        exp_addr = ax.addr & ((axi_addr_t'(1) << addr_mask_msb) - 1);
        do begin
            @(posedge clk);
            trans_ready <= ready_bit();
            @(negedge clk);
        end while (!(trans_valid && trans_ready));
        check_value("trans_o.write", trans.write, write);
        check_value("trans_o.burst_type", trans.burst_type, 1);
        check_value("trans_o.address_space", trans.address_space, addr_space);
        check_value("trans_o.address", trans.address, exp_addr >> 1);
        check_value("trans_o.burst", trans.burst, (ax.len + 1) * words_per_beat(ax.size));
        check_value("trans_cs_o", trans_cs, 2'b01 << ax.addr[addr_mask_msb]);
        next_tie_write = ~write;
        @(posedge clk);
        trans_ready <= 1'b0;
        @(negedge clk);
        check_value("trans_active_o", trans_active, 1);
    endtask

    task automatic recv_tx(input axi_ax_t ax);
        int total;
        int n;
        int lane;
        int beat;
        total = (ax.len + 1) * words_per_beat(ax.size);
        n     = 0;
        while (n < total) begin
            @(posedge clk);
            tx_ready <= ready_bit();
            @(negedge clk);
            if (tx_valid && tx_ready) begin
                lane = (int'(ax.addr[2:1]) + n) % WORDS_PER_BEAT;
                beat = n / words_per_beat(ax.size);
                check_value("tx_o.data", tx.data, w_data[beat][16*lane +: 16]);
                check_value("tx_o.strb", tx.strb, w_strb[beat][2*lane +: 2]);
                check_value("tx_o.last", tx.last, n == total - 1);
                n++;
            end
        end
        @(posedge clk);
        tx_ready <= 1'b0;
    endtask

    task automatic send_b(input logic err);
        @(posedge clk);
        phy_b_valid <= 1'b1;
        phy_b_error <= err;
        @(negedge clk);
        while (!phy_b_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        phy_b_valid <= 1'b0;
        phy_b_error <= 1'b0;
    endtask

    task automatic send_rx(input axi_ax_t ax);
        int total;
        total = (ax.len + 1) * words_per_beat(ax.size);
        for (int n = 0; n < total; n++) begin
            @(posedge clk);
            rx.data  <= rx_data[n];
            rx.last  <= (n == total - 1);
            rx.error <= rx_err[n];
            rx_valid <= 1'b1;
            @(negedge clk);
            while (!rx_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic complete_write(input axi_ax_t ax, input logic err);
        accept_trans(ax, 1'b1);
        recv_tx(ax);
        send_b(err);
    endtask

    task automatic complete_read(input axi_ax_t ax);
        accept_trans(ax, 1'b0);
        send_rx(ax);
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic run_write(input axi_ax_t ax, input logic err);
        fill_w(ax);
        fork
            send_ax(1'b1, ax);
            send_w(ax);
            recv_b(ax.id, err);
            complete_write(ax, err);
        join
        @(negedge clk);
        check_value("trans_active_o", trans_active, 0);
    endtask

    task automatic run_read(input axi_ax_t ax, input int err_word);
        fill_rx(ax, err_word);
        fork
            send_ax(1'b0, ax);
            recv_r(ax);
            complete_read(ax);
        join
        @(negedge clk);
        check_value("trans_active_o", trans_active, 0);
    endtask

    // AW and AR raised in the same cycle so that the priority bit picks the winner
    task automatic run_tie_round(input axi_ax_t aw_ax, input axi_ax_t ar_ax);
        logic first_write;
        first_write = next_tie_write;
        fill_w(aw_ax);
        fill_rx(ar_ax, -1);
        fork
            send_ax(1'b1, aw_ax);
            send_ax(1'b0, ar_ax);
            send_w(aw_ax);
            recv_b(aw_ax.id, 1'b0);
            recv_r(ar_ax);
            begin
                if (first_write) begin
                    complete_write(aw_ax, 1'b0);
                    complete_read(ar_ax);
                end else begin
                    complete_read(ar_ax);
                    complete_write(aw_ax, 1'b0);
                end
            end
        join
    endtask

    initial begin
        stall_en       = 1'b0;
        next_tie_write = 1'b0;
        aw            <= '0;
        aw_valid      <= 1'b0;
        ar            <= '0;
        ar_valid      <= 1'b0;
        w             <= '0;
        w_valid       <= 1'b0;
        r_ready       <= 1'b0;
        b_ready       <= 1'b0;
        rx            <= '0;
        rx_valid      <= 1'b0;
        tx_ready      <= 1'b0;
        phy_b_error   <= 1'b0;
        phy_b_valid   <= 1'b0;
        trans_ready   <= 1'b0;
        addr_mask_msb <= 5'd23;
        addr_space    <= 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("trans_valid_o", trans_valid, 0);
        check_value("tx_valid_o", tx_valid, 0);
        check_value("r_valid_o", r_valid, 0);
        check_value("b_valid_o", b_valid, 0);
        check_value("trans_active_o", trans_active, 0);
        check_value("aw_ready_o", aw_ready, 0);
        check_value("ar_ready_o", ar_ready, 0);
        check_value("rx_ready_o", rx_ready, 1);
        check_value("w_ready_o", w_ready, 1);

        run_write(make_ax(3'd3, 8'd3), 1'b1);
        run_read(make_ax(3'd1, 8'd5), -1);
        run_read(make_ax(3'd2, 8'd3), 2);
        run_read(make_ax(3'd3, 8'd1), 5);
        run_tie_round(make_ax(3'd3, 8'd1), make_ax(3'd2, 8'd2));
        // A write grant in between hands the next tie to AR
        run_write(make_ax(3'd3, 8'd0), 1'b0);
        run_tie_round(make_ax(3'd2, 8'd2), make_ax(3'd3, 8'd0));

        // Random back-pressure on every ready driven here
        stall_en = 1'b1;
        repeat (3) begin
            run_write(make_ax(3'd3, 8'd3), 1'b0);
            run_write(make_ax(3'd1, 8'd4), 1'b0);
            run_read(make_ax(3'd3, 8'd7), 9);
            run_read(make_ax(3'd1, 8'd6), -1);
        end

        // New mask position and address space
        @(posedge clk);
        addr_mask_msb <= 5'd27;
        addr_space    <= 1'b1;
        repeat (3) begin
            run_read(make_ax(3'd2, 8'd2), -1);
            run_write(make_ax(3'd3, 8'd0), 1'b0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- filelist.f
common/hbus_axi_pkg.sv
common/hbus_phy_pkg.sv
hbus_axi/hbus_ax_channel.sv
hbus_axi/hbus_xfer_tracker.sv
hbus_axi/hbus_r_coalesce.sv
hbus_axi/hbus_w_serialize.sv
hbus_axi/hbus_axi_top.sv
sim/tb_clk_gen.sv
sim/tb_hbus_axi_top.sv

//--- Bender.yml
package:
  name: hbus_axi

sources:
  # Packages first, then the front-end blocks and the top level
  - files:
      - common/hbus_axi_pkg.sv
      - common/hbus_phy_pkg.sv
      - hbus_axi/hbus_ax_channel.sv
      - hbus_axi/hbus_xfer_tracker.sv
      - hbus_axi/hbus_r_coalesce.sv
      - hbus_axi/hbus_w_serialize.sv
      - hbus_axi/hbus_axi_top.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_hbus_axi_top.sv
